// File: Makefile
TB = nn_tb

all: run

run:
	verilator --binary --timing -f nn.f --top-module $(TB) -o $(TB)
	./obj_dir/$(TB)

lint:
	verilator --lint-only --timing -f nn.f --top-module nn

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: hw/nn.sv
`timescale 1ns/1ns

module nn (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   enable,
    input  nn_data_pkg::nn_word_t  input_1,
    input  nn_data_pkg::nn_word_t  input_2,
    output nn_data_pkg::nn_word_t  final_output,
    output logic                   total_ovf,
    output logic                   total_zero,
    output nn_ctrl_pkg::nn_stage_e ovf_stage,
    output nn_ctrl_pkg::nn_stage_e zero_stage,
    output logic                   done
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    // ROM to register file
    nn_rom_addr_t      rom_addr_a;
    nn_rom_addr_t      rom_addr_b;
    nn_word_t          rom_data_a;
    nn_word_t          rom_data_b;
    logic              rf_write;
    nn_rf_addr_t       rf_wr_addr_a;
    nn_rf_addr_t       rf_wr_addr_b;
    nn_word_t          rf_wr_data_a;
    nn_word_t          rf_wr_data_b;
    nn_rf_addr_t [3:0] rf_rd_addr;
    nn_word_t    [3:0] rf_rd_data;

    // Arithmetic unit operands and results
    nn_word_t    [1:0] alu_value;
    nn_word_t    [1:0] alu_amount;
    logic        [1:0] alu_left;
    nn_word_t    [1:0] alu_result;
    nn_flags_t   [1:0] alu_flags;
    nn_word_t    [1:0] mac_multiplicand;
    nn_word_t    [1:0] mac_weight;
    nn_word_t    [1:0] mac_addend;
    nn_word_t    [1:0] mac_result;
    nn_flags_t   [1:0] mac_flags;

    nn_weight_rom u_rom (
        .clk    (clk),
        .addr_a (rom_addr_a),
        .addr_b (rom_addr_b),
        .data_a (rom_data_a),
        .data_b (rom_data_b)
    );

    nn_param_regfile u_regfile (
        .clk       (clk),
        .resetn    (resetn),
        .write     (rf_write),
        .wr_addr_a (rf_wr_addr_a),
        .wr_addr_b (rf_wr_addr_b),
        .wr_data_a (rf_wr_data_a),
        .wr_data_b (rf_wr_data_b),
        .rd_addr   (rf_rd_addr),
        .rd_data   (rf_rd_data)
    );

    // Two shift ALUs and two MACs side by side
    for (genvar i = 0; i < 2; i++) begin : g_unit
        nn_shift_alu u_alu (
            .value  (alu_value[i]),
            .amount (alu_amount[i]),
            .left   (alu_left[i]),
            .result (alu_result[i]),
            .flags  (alu_flags[i])
        );

        nn_mac u_mac (
            .multiplicand (mac_multiplicand[i]),
            .weight       (mac_weight[i]),
            .addend       (mac_addend[i]),
            .result       (mac_result[i]),
            .flags        (mac_flags[i])
        );
    end

    nn_sequencer u_seq (.*);  // Port names match the nets above

endmodule

// File: hw/nn_ctrl_pkg.sv
package nn_ctrl_pkg;

    // ======================================
    // Sequencer states and stage codes
    // ======================================
    typedef enum logic [2:0] {
        DEACTIVATED,
        LOADING,
        IDLE,
        PREPROCESS,
        INPUT_LAYER,
        OUTPUT_A,    // Neuron 3 first MAC
        OUTPUT_B,    // Neuron 3 second MAC
        POSTPROCESS
    } nn_state_e;

    // Reported stage, separate from the state code
    typedef enum logic [2:0] {
        PRE   = 3'd0,
        INPUT = 3'd1,
        OUT_A = 3'd2,
        OUT_B = 3'd3,
        POST  = 3'd4,
        NONE  = 3'd7
    } nn_stage_e;

    typedef logic [3:0] nn_rf_addr_t;   // Register file slot
    typedef logic [7:0] nn_rom_addr_t;  // ROM byte address
    typedef logic [2:0] nn_load_cnt_t;  // Load step counter

    // ======================================
    // Register file map
    // ======================================
    localparam nn_rf_addr_t NN_ADDR_SHIFT_1 = 4'd2;  // First parameter slot
    localparam nn_rf_addr_t NN_ADDR_SHIFT_2 = 4'd3;
    localparam nn_rf_addr_t NN_ADDR_W1      = 4'd4;
    localparam nn_rf_addr_t NN_ADDR_B1      = 4'd5;
    localparam nn_rf_addr_t NN_ADDR_W2      = 4'd6;
    localparam nn_rf_addr_t NN_ADDR_B2      = 4'd7;
    localparam nn_rf_addr_t NN_ADDR_W3      = 4'd8;
    localparam nn_rf_addr_t NN_ADDR_W4      = 4'd9;
    localparam nn_rf_addr_t NN_ADDR_B3      = 4'd10;
    localparam nn_rf_addr_t NN_ADDR_SHIFT_3 = 4'd11;

    // ROM layout, parameters in slot order
    localparam nn_rom_addr_t NN_ROM_BASE   = 8'd8;
    localparam nn_rom_addr_t NN_ROM_STRIDE = 8'd4;   // Bytes per word
    localparam nn_load_cnt_t NN_LOAD_STEPS = 3'd5;   // Pairs copied

endpackage

// File: hw/nn_data_pkg.sv
package nn_data_pkg;

    // ======================================
    // Data path widths
    // ======================================
    localparam int NN_WIDTH      = 32;
    localparam int NN_SHIFT_BITS = $clog2(NN_WIDTH);  // Shift amount bits used

    // Signed fixed-point word
    typedef logic signed [NN_WIDTH-1:0] nn_word_t;

    // Status from each arithmetic unit
    typedef struct packed {
        logic ovf;   // Result not representable
        logic zero;  // Result equals zero
    } nn_flags_t;

    // Output word forced on overflow
    localparam nn_word_t NN_OVF_VALUE = '1;

endpackage

// File: hw/nn_mac.sv
`timescale 1ns/1ns

module nn_mac (
    input  nn_data_pkg::nn_word_t  multiplicand,
    input  nn_data_pkg::nn_word_t  weight,
    input  nn_data_pkg::nn_word_t  addend,
    output nn_data_pkg::nn_word_t  result,
    output nn_data_pkg::nn_flags_t flags
);
    import nn_data_pkg::*;

    logic signed [2*NN_WIDTH-1:0] product;  // Full signed product
    nn_word_t                     prod_lo;
    logic                         mul_ovf;
    logic                         add_ovf;

    assign product = (2*NN_WIDTH)'(multiplicand) * (2*NN_WIDTH)'(weight);
    assign prod_lo = product[NN_WIDTH-1:0];

    // Product fits only if the upper half is the sign extension of the lower
    assign mul_ovf = (product != (2*NN_WIDTH)'(prod_lo));

    assign result = prod_lo + addend;

    // Same-sign operands giving an opposite-sign sum
    assign add_ovf = (prod_lo[NN_WIDTH-1] == addend[NN_WIDTH-1])
                  && (result[NN_WIDTH-1] != addend[NN_WIDTH-1]);

    assign flags.ovf  = mul_ovf | add_ovf;
    assign flags.zero = (result == '0);

endmodule

// File: hw/nn_param_regfile.sv
`timescale 1ns/1ns

module nn_param_regfile (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           write,
    input  nn_ctrl_pkg::nn_rf_addr_t       wr_addr_a,
    input  nn_ctrl_pkg::nn_rf_addr_t       wr_addr_b,
    input  nn_data_pkg::nn_word_t          wr_data_a,
    input  nn_data_pkg::nn_word_t          wr_data_b,
    input  nn_ctrl_pkg::nn_rf_addr_t [3:0] rd_addr,
    output nn_data_pkg::nn_word_t    [3:0] rd_data
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    nn_word_t regs [2**$bits(nn_rf_addr_t)];  // 16 parameter words

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 2**$bits(nn_rf_addr_t); i++) begin
                regs[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (write) begin
                regs[wr_addr_a] <= wr_data_a;
                regs[wr_addr_b] <= wr_data_b;  // Port b wins on same slot
            end
            // All four reads land one clock after the address
            for (int p = 0; p < 4; p++) begin
                rd_data[p] <= regs[rd_addr[p]];
            end
        end
    end

endmodule

// File: hw/nn_sequencer.sv
`timescale 1ns/1ns

module nn_sequencer (
    input  logic                           clk,
    input  logic                           resetn,
    input  logic                           enable,
    input  nn_data_pkg::nn_word_t          input_1,
    input  nn_data_pkg::nn_word_t          input_2,
    // ROM side
    output nn_ctrl_pkg::nn_rom_addr_t      rom_addr_a,
    output nn_ctrl_pkg::nn_rom_addr_t      rom_addr_b,
    input  nn_data_pkg::nn_word_t          rom_data_a,
    input  nn_data_pkg::nn_word_t          rom_data_b,
    // Register file write side
    output logic                           rf_write,
    output nn_ctrl_pkg::nn_rf_addr_t       rf_wr_addr_a,
    output nn_ctrl_pkg::nn_rf_addr_t       rf_wr_addr_b,
    output nn_data_pkg::nn_word_t          rf_wr_data_a,
    output nn_data_pkg::nn_word_t          rf_wr_data_b,
    // Register file read side
    output nn_ctrl_pkg::nn_rf_addr_t [3:0] rf_rd_addr,
    input  nn_data_pkg::nn_word_t    [3:0] rf_rd_data,
    // Shift ALUs
    output nn_data_pkg::nn_word_t    [1:0] alu_value,
    output nn_data_pkg::nn_word_t    [1:0] alu_amount,
    output logic                     [1:0] alu_left,
    input  nn_data_pkg::nn_word_t    [1:0] alu_result,
    input  nn_data_pkg::nn_flags_t   [1:0] alu_flags,
    // MACs
    output nn_data_pkg::nn_word_t    [1:0] mac_multiplicand,
    output nn_data_pkg::nn_word_t    [1:0] mac_weight,
    output nn_data_pkg::nn_word_t    [1:0] mac_addend,
    input  nn_data_pkg::nn_word_t    [1:0] mac_result,
    input  nn_data_pkg::nn_flags_t   [1:0] mac_flags,
    // Results
    output nn_data_pkg::nn_word_t          final_output,
    output logic                           total_ovf,
    output logic                           total_zero,
    output nn_ctrl_pkg::nn_stage_e         ovf_stage,
    output nn_ctrl_pkg::nn_stage_e         zero_stage,
    output logic                           done
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    nn_state_e    state;
    nn_state_e    next_state;
    nn_load_cnt_t load_cnt;        // Pair being fetched
    logic         loaded;          // Parameters already copied
    nn_word_t     inter_1;         // Shifted inputs
    nn_word_t     inter_2;
    nn_word_t     inter_3;         // Input neuron outputs
    nn_word_t     inter_4;
    nn_word_t     inter_5;         // Output neuron before post shift
    nn_word_t     partial;         // inter_3 * w3 + b3
    nn_stage_e    run_zero_stage;  // Last zero stage so far in this run

    nn_stage_e    cur_stage;       // Stage code of current state
    logic         stage_ovf;
    logic         stage_zero;
    logic         busy;            // In one of the five run stages
    logic         finish;          // Run ends this cycle
    nn_stage_e    zero_at;         // Zero stage including this cycle

    // ======================================
    // Parameter load path
    // ======================================
    // Pair k sits at base + 2k strides
    assign rom_addr_a = NN_ROM_BASE + nn_rom_addr_t'({load_cnt, 1'b0}) * NN_ROM_STRIDE;
    assign rom_addr_b = rom_addr_a + NN_ROM_STRIDE;

    // ROM data is one cycle late so writes trail the count by one
    assign rf_write     = (state == LOADING) && (load_cnt != '0);
    assign rf_wr_addr_a = NN_ADDR_SHIFT_1 + nn_rf_addr_t'({load_cnt - 3'd1, 1'b0});
    assign rf_wr_addr_b = rf_wr_addr_a + 4'd1;
    assign rf_wr_data_a = rom_data_a;
    assign rf_wr_data_b = rom_data_b;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= DEACTIVATED;
            load_cnt <= '0;
            loaded   <= 1'b0;
        end else begin
            state <= next_state;
            if (state == LOADING) begin
                if (load_cnt == NN_LOAD_STEPS) begin
                    loaded <= 1'b1;  // Last pair written this cycle
                end else begin
                    load_cnt <= load_cnt + 3'd1;
                end
            end
        end
    end

    // ======================================
    // Next state and operand selection
    // ======================================
    // Read addresses always target the following state
    always_comb begin
        next_state       = state;
        cur_stage        = NONE;
        stage_ovf        = 1'b0;
        stage_zero       = 1'b0;
        rf_rd_addr       = '0;
        alu_value        = '0;
        alu_amount       = '0;
        alu_left         = '0;
        mac_multiplicand = '0;
        mac_weight       = '0;
        mac_addend       = '0;
        case (state)
            DEACTIVATED: begin
                if (enable) begin
                    next_state = loaded ? IDLE : LOADING;
                end
            end
            LOADING: begin
                if (load_cnt == NN_LOAD_STEPS) begin
                    next_state = IDLE;
                end
            end
            IDLE: begin
                rf_rd_addr[0] = NN_ADDR_SHIFT_1;  // Input shifts
                rf_rd_addr[1] = NN_ADDR_SHIFT_2;
                if (enable) begin
                    next_state = PREPROCESS;
                end
            end
            PREPROCESS: begin
                cur_stage     = PRE;
                alu_value[0]  = input_1;
                alu_amount[0] = rf_rd_data[0];
                alu_value[1]  = input_2;
                alu_amount[1] = rf_rd_data[1];
                stage_ovf     = alu_flags[0].ovf | alu_flags[1].ovf;
                stage_zero    = alu_flags[0].zero | alu_flags[1].zero;
                rf_rd_addr    = {NN_ADDR_B2, NN_ADDR_W2, NN_ADDR_B1, NN_ADDR_W1};
                next_state    = stage_ovf ? IDLE : INPUT_LAYER;
            end
            INPUT_LAYER: begin
                cur_stage           = INPUT;
                mac_multiplicand[0] = inter_1;        // Neuron 1
                mac_weight[0]       = rf_rd_data[0];
                mac_addend[0]       = rf_rd_data[1];
                mac_multiplicand[1] = inter_2;        // Neuron 2
                mac_weight[1]       = rf_rd_data[2];
                mac_addend[1]       = rf_rd_data[3];
                stage_ovf           = mac_flags[0].ovf | mac_flags[1].ovf;
                stage_zero          = mac_flags[0].zero | mac_flags[1].zero;
                rf_rd_addr[0]       = NN_ADDR_W3;
                rf_rd_addr[1]       = NN_ADDR_B3;
                next_state          = stage_ovf ? IDLE : OUTPUT_A;
            end
            OUTPUT_A: begin
                cur_stage           = OUT_A;
                mac_multiplicand[0] = inter_3;
                mac_weight[0]       = rf_rd_data[0];  // w3
                mac_addend[0]       = rf_rd_data[1];  // b3
                stage_ovf           = mac_flags[0].ovf;
                stage_zero          = mac_flags[0].zero;
                rf_rd_addr[0]       = NN_ADDR_W4;
                next_state          = stage_ovf ? IDLE : OUTPUT_B;
            end
            OUTPUT_B: begin
                cur_stage           = OUT_B;
                mac_multiplicand[0] = inter_4;
                mac_weight[0]       = rf_rd_data[0];  // w4
                mac_addend[0]       = partial;        // Chained from OUTPUT_A
                stage_ovf           = mac_flags[0].ovf;
                stage_zero          = mac_flags[0].zero;
                rf_rd_addr[0]       = NN_ADDR_SHIFT_3;
                next_state          = stage_ovf ? IDLE : POSTPROCESS;
            end
            POSTPROCESS: begin
                cur_stage     = POST;
                alu_value[0]  = inter_5;
                alu_amount[0] = rf_rd_data[0];
                alu_left[0]   = 1'b1;
                stage_ovf     = alu_flags[0].ovf;
                stage_zero    = alu_flags[0].zero;
                next_state    = IDLE;
            end
            default: begin
                next_state = DEACTIVATED;
            end
        endcase
    end

    assign busy    = (cur_stage != NONE);
    assign finish  = busy && (stage_ovf || state == POSTPROCESS);
    assign zero_at = stage_zero ? cur_stage : run_zero_stage;  // Latest zero wins

    // ======================================
    // Intermediates
    // ======================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            inter_1 <= '0;
            inter_2 <= '0;
            inter_3 <= '0;
            inter_4 <= '0;
            inter_5 <= '0;
            partial <= '0;
        end else begin
            case (state)
                PREPROCESS: begin
                    inter_1 <= alu_result[0];
                    inter_2 <= alu_result[1];
                end
                INPUT_LAYER: begin
                    inter_3 <= mac_result[0];
                    inter_4 <= mac_result[1];
                end
                OUTPUT_A: begin
                    partial <= mac_result[0];
                end
                OUTPUT_B: begin
                    inter_5 <= mac_result[0];
                end
                default: begin
                end
            endcase
        end
    end

    // ======================================
    // Result and flag registers
    // ======================================
    // Outputs change only together with done
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            run_zero_stage <= NONE;
            done           <= 1'b0;
            final_output   <= '0;
            total_ovf      <= 1'b0;
            total_zero     <= 1'b0;
            ovf_stage      <= NONE;
            zero_stage     <= NONE;
        end else begin
            done           <= finish;
            run_zero_stage <= busy ? zero_at : NONE;  // Fresh for every run
            if (finish) begin
                final_output <= stage_ovf ? NN_OVF_VALUE : alu_result[0];
                total_ovf    <= stage_ovf;
                ovf_stage    <= stage_ovf ? cur_stage : NONE;
                total_zero   <= (zero_at != NONE);
                zero_stage   <= zero_at;
            end
        end
    end

endmodule

// File: hw/nn_shift_alu.sv
`timescale 1ns/1ns

module nn_shift_alu (
    input  nn_data_pkg::nn_word_t  value,
    input  nn_data_pkg::nn_word_t  amount,
    input  logic                   left,    // 1 for left shift, 0 for right
    output nn_data_pkg::nn_word_t  result,
    output nn_data_pkg::nn_flags_t flags
);
    import nn_data_pkg::*;

    logic [NN_SHIFT_BITS-1:0] sh;  // Effective shift distance

    assign sh = amount[NN_SHIFT_BITS-1:0];

    // Right shift copies the sign bit in
    assign result = left ? (value <<< sh) : (value >>> sh);

    // Left shift is exact only if shifting back restores the value
    // True when the dropped bits and the new sign all match the old sign
    assign flags.ovf  = left && ((result >>> sh) != value);
    assign flags.zero = (result == '0);

endmodule

// File: hw/nn_weight_rom.sv
`timescale 1ns/1ns

module nn_weight_rom (
    input  logic                      clk,
    input  nn_ctrl_pkg::nn_rom_addr_t addr_a,
    input  nn_ctrl_pkg::nn_rom_addr_t addr_b,
    output nn_data_pkg::nn_word_t     data_a,
    output nn_data_pkg::nn_word_t     data_b
);
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    // One entry per word of the byte address space
    nn_word_t mem [2**$bits(nn_rom_addr_t) / NN_ROM_STRIDE];

    initial begin
        $readmemh("hw/nn_weights.hex", mem);
    end

    // Registered reads, byte address dropped to word index
    always_ff @(posedge clk) begin
        data_a <= mem[addr_a[$bits(nn_rom_addr_t)-1:$clog2(NN_ROM_STRIDE)]];
        data_b <= mem[addr_b[$bits(nn_rom_addr_t)-1:$clog2(NN_ROM_STRIDE)]];
    end

endmodule

// File: hw/nn_weights.hex
// One 32-bit parameter word per line, line n is ROM byte address 4*n
// Words 2 to 11 map to register file slots 2 to 11
00000000 // Unused
00000000 // Unused
00000001 // shift_1
00000002 // shift_2
00000003 // w1
00000005 // b1
FFFFFFFE // w2 = -2
00000007 // b2
00000004 // w3
FFFFFFFD // w4 = -3
00000001 // b3
00000002 // shift_3

// File: nn.f
hw/nn_data_pkg.sv
hw/nn_ctrl_pkg.sv
hw/nn_weight_rom.sv
hw/nn_param_regfile.sv
hw/nn_shift_alu.sv
hw/nn_mac.sv
hw/nn_sequencer.sv
hw/nn.sv
test/nn_tb.sv

// File: test/nn_tb.sv
`timescale 1ns/1ns

module nn_tb;
    import nn_data_pkg::*;
    import nn_ctrl_pkg::*;

    // Expected outcome of one run
    typedef struct packed {
        nn_word_t  out;
        logic      ovf;
        logic      zero;
        nn_stage_e ovf_stage;
        nn_stage_e zero_stage;
    } result_t;

    typedef struct packed {
        nn_word_t in_1;
        nn_word_t in_2;
        logic     hold;  // Keep enable high through the run
        result_t  exp;
    } vector_t;

    localparam int NUM_ENTRIES    = 10;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ENTRIES + 40;
    localparam int LOAD_CYCLES    = 6;  // Five address steps with the last write one behind
    localparam int RUN_CYCLES     = 5;
    localparam int ROM_WORDS      = 2**$bits(nn_rom_addr_t) / NN_ROM_STRIDE;

    typedef logic [$clog2(ROM_WORDS)-1:0] rom_index_t;

    logic      clk;
    logic      resetn;
    logic      enable;
    nn_word_t  input_1;
    nn_word_t  input_2;
    nn_word_t  final_output;
    logic      total_ovf;
    logic      total_zero;
    nn_stage_e ovf_stage;
    nn_stage_e zero_stage;
    logic      done;

    nn_word_t    rom_image [ROM_WORDS];  // Model copy of the weight ROM
    vector_t     vectors [NUM_ENTRIES];
    int          num_built   = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state   = 32'd39871;

    nn DUT (.*);

    always #50 clk = ~clk;  // 100 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout, run not finished after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic nn_word_t rom_param(input int k);
        rom_index_t word;
        word = rom_index_t'((NN_ROM_BASE + k * NN_ROM_STRIDE) / NN_ROM_STRIDE);
        return rom_image[word];
    endfunction

    function automatic logic fits_word(input longint x);
        return (x >= -(longint'(1) << 31)) && (x < (longint'(1) << 31));
    endfunction

    function automatic nn_flags_t shr_ref(input nn_word_t v, input nn_word_t amt,
                                          output nn_word_t r);
        nn_flags_t f;
        r      = v >>> amt[4:0];  // Sign fill never overflows
        f.ovf  = 1'b0;
        f.zero = (r == '0);
        return f;
    endfunction

    // Left shift as multiply by a power of two
    function automatic nn_flags_t shl_ref(input nn_word_t v, input nn_word_t amt,
                                          output nn_word_t r);
        longint    full;
        nn_flags_t f;
        full   = longint'(v) * (longint'(1) << amt[4:0]);
        r      = nn_word_t'(full[31:0]);
        f.ovf  = !fits_word(full);
        f.zero = (r == '0);
        return f;
    endfunction

    function automatic nn_flags_t mac_ref(input nn_word_t a, input nn_word_t w,
                                          input nn_word_t c, output nn_word_t r);
        longint    prod;
        longint    sum;
        nn_flags_t f;
        prod   = longint'(a) * longint'(w);
        sum    = longint'(nn_word_t'(prod[31:0])) + longint'(c);  // Low product word
        r      = nn_word_t'(sum[31:0]);
        f.ovf  = !fits_word(prod) || !fits_word(sum);
        f.zero = (r == '0);
        return f;
    endfunction

    // Record one stage and return 1 when the run stops here
    function automatic logic stage_ends(input nn_stage_e st, input nn_flags_t f0,
                                        input nn_flags_t f1, inout result_t res);
        if (f0.zero || f1.zero) begin
            res.zero       = 1'b1;
            res.zero_stage = st;  // Later zero wins
        end
        if (f0.ovf || f1.ovf) begin
            res.ovf       = 1'b1;
            res.ovf_stage = st;
            res.out       = NN_OVF_VALUE;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic result_t run_model(input nn_word_t in_1, input nn_word_t in_2);
        result_t   res;
        nn_word_t  a;     // Shifted inputs
        nn_word_t  b;
        nn_word_t  c;     // Input neuron outputs
        nn_word_t  d;
        nn_word_t  part;
        nn_word_t  e;
        nn_word_t  y;
        nn_flags_t fa;
        nn_flags_t fb;
        res = '{out: '0, ovf: 1'b0, zero: 1'b0, ovf_stage: NONE, zero_stage: NONE};
        fa = shr_ref(in_1, rom_param(0), a);
        fb = shr_ref(in_2, rom_param(1), b);
        if (stage_ends(PRE, fa, fb, res)) return res;
        fa = mac_ref(a, rom_param(2), rom_param(3), c);  // Neuron 1
        fb = mac_ref(b, rom_param(4), rom_param(5), d);  // Neuron 2
        if (stage_ends(INPUT, fa, fb, res)) return res;
        fa = mac_ref(c, rom_param(6), rom_param(8), part);
        if (stage_ends(OUT_A, fa, '0, res)) return res;
        fa = mac_ref(d, rom_param(7), part, e);
        if (stage_ends(OUT_B, fa, '0, res)) return res;
        fa = shl_ref(e, rom_param(9), y);
        if (stage_ends(POST, fa, '0, res)) return res;
        res.out = y;
        return res;
    endfunction

    // Start edge to done
    function automatic int run_cycles(input result_t r);
        return r.ovf ? int'(r.ovf_stage) + 1 : RUN_CYCLES;
    endfunction

    function automatic nn_word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return nn_word_t'(lcg_state) >>> 12;  // About +-2**19
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input string name, input nn_word_t got, input nn_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            abort_run({"Wrong value on ", name});
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            abort_run({"Wrong value on ", name});
        end
    endtask

    task automatic check_stage(input string name, input nn_stage_e got, input nn_stage_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %s, expected %s", $time, name,
                     got.name(), exp.name());
            abort_run({"Wrong value on ", name});
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
            abort_run({"Wrong timing on ", name});
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic add_entry(input nn_word_t in_1, input nn_word_t in_2, input logic hold);
        vectors[num_built].in_1 = in_1;
        vectors[num_built].in_2 = in_2;
        vectors[num_built].hold = hold;
        vectors[num_built].exp  = run_model(in_1, in_2);
        num_built++;
    endtask

    task automatic build_table();
        nn_word_t r1;
        nn_word_t r2;
        $readmemh("hw/nn_weights.hex", rom_image);
        add_entry(32'sd100, 32'sd200, 1'b1);           // Includes loading
        add_entry(32'sd1, 32'sd3, 1'b0);               // Shifts to zero
        add_entry(32'h7FFF_FFFF, 32'sd16, 1'b0);       // Neuron 1 overflow
        add_entry(32'h0800_0000, 32'sd0, 1'b0);        // Final shift overflow
        add_entry(32'sd50, -32'sd40, 1'b1);            // Back to back from here
        add_entry(32'h7FFF_FFFF, 32'sd0, 1'b1);
        add_entry(32'sd1, 32'sd3, 1'b1);
        r1 = lcg_next();
        r2 = lcg_next();
        add_entry(r1, r2, 1'b1);
        r1 = lcg_next();
        r2 = lcg_next();
        add_entry(r1, r2, 1'b0);
        add_entry(-32'sd1000, 32'sd999, 1'b0);
    endtask

    // Called on a falling edge with the DUT idle
    task automatic apply_entry(input int idx);
        vector_t v;
        int      latency;
        int      expected;
        v        = vectors[idx];
        expected = run_cycles(v.exp) + ((idx == 0) ? LOAD_CYCLES + 1 : 0);
        input_1  = v.in_1;
        input_2  = v.in_2;
        enable   = 1'b1;
        @(posedge clk);  // Start edge
        @(negedge clk);
        if (!v.hold) begin
            enable = 1'b0;
        end
        latency = 0;
        while (!done) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end
        check_cycles("done latency", latency, expected);
        check_word("final_output", final_output, v.exp.out);
        check_flag("total_ovf", total_ovf, v.exp.ovf);
        check_flag("total_zero", total_zero, v.exp.zero);
        check_stage("ovf_stage", ovf_stage, v.exp.ovf_stage);
        check_stage("zero_stage", zero_stage, v.exp.zero_stage);
        if (!v.hold) begin
            // Result must hold through the idle gap
            repeat (2) begin
                @(negedge clk);
                check_flag("done", done, 1'b0);
                check_word("final_output", final_output, v.exp.out);
            end
        end
    endtask

    initial begin
        clk     = 1'b0;
        resetn  = 1'b0;
        enable  = 1'b0;
        input_1 = '0;
        input_2 = '0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_word("final_output", final_output, '0);  // Reset values
        check_flag("total_ovf", total_ovf, 1'b0);
        check_flag("total_zero", total_zero, 1'b0);
        check_stage("ovf_stage", ovf_stage, NONE);
        check_stage("zero_stage", zero_stage, NONE);
        check_flag("done", done, 1'b0);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            apply_entry(i);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
